// ==== design/iccm_bank.sv ====
`timescale 1ns/1ps
/*
   One ICCM bank of 64 words with a one cycle registered read
   Read data holds while the bank is not read
   Redundant row data replaces array data when a valid row tag matches
   Array contents have no reset
*/
module iccm_bank #(
   parameter int BANK_ID = 0                         // Bank number in the address
) (
   input  logic                                   clk,
   input  logic                                   rst_n,
   input  logic                                   bank_wren,
   input  logic                                   bank_rden,
   input  logic [iccm_pkg::BANK_INDEX_BITS-1:0]   bank_row,
   input  logic [iccm_pkg::WORD_W-1:0]            bank_wr_word,
   input  iccm_pkg::iccm_addr_u                   iccm_rw_addr,
   input  iccm_pkg::iccm_addr_u                   addr_inc,
   input  logic [1:0][iccm_pkg::TAG_W-1:0]        red_tag,
   input  logic [1:0]                             red_valid,
   input  logic [1:0][iccm_pkg::WORD_W-1:0]       red_data,
   output logic [1:0]                             sel_red,
   output logic [iccm_pkg::WORD_W-1:0]            bank_dout
);
   import iccm_pkg::*;

   logic [WORD_W-1:0] mem [BANK_DEPTH];   // Behavioral storage
   logic [WORD_W-1:0] rd_q;               // Registered array read
   logic [1:0]        sel_red_q;          // Match aligned with rd_q
   logic              own_first;          // First word sits in this bank
   logic              own_second;
   logic [1:0]        tag_hit_first;
   logic [1:0]        tag_hit_second;

   // ************************************************************
   // Storage
   // ************************************************************
   always_ff @(posedge clk) begin
      if (bank_wren) begin
         mem[bank_row] <= bank_wr_word;
      end
      if (bank_rden) begin
         rd_q <= mem[bank_row];           // Old data on a same row write
      end
   end

   // ************************************************************
   // Redundant row match
   // ************************************************************
   assign own_first  = (iccm_rw_addr.t.tag[BANK_BITS-1:0] == BANK_BITS'(BANK_ID));
   assign own_second = (addr_inc.t.tag[BANK_BITS-1:0] == BANK_BITS'(BANK_ID));

   for (genvar r = 0; r < 2; r++) begin : g_row
      assign tag_hit_first[r]  = own_first & (iccm_rw_addr.t.tag == red_tag[r]);
      assign tag_hit_second[r] = own_second & (addr_inc.t.tag == red_tag[r]);
      assign sel_red[r]        = red_valid[r] & (tag_hit_first[r] | tag_hit_second[r]);
   end

   // Match follows the array by one cycle
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         sel_red_q <= 2'b00;
      end else begin
         sel_red_q <= sel_red;
      end
   end

   // Substitution on the way out
   always_comb begin
      bank_dout = rd_q;
      if (sel_red_q[0]) begin
         bank_dout = red_data[0];
      end
      if (sel_red_q[1]) begin
         bank_dout = red_data[1];         // Row 1 wins on a double hit
      end
   end

endmodule

// ==== design/iccm_bank_decode.sv ====
`timescale 1ns/1ps
/*
   Bank enables, rows and write words for both words of an access
   A halfword aligned word access also touches two banks
   When both words fall in one bank the first word owns the row
*/
module iccm_bank_decode (
   input  logic                                   iccm_wren,
   input  logic                                   iccm_rden,
   input  iccm_pkg::iccm_addr_u                   iccm_rw_addr,
   input  logic [2:0]                             iccm_wr_size,
   input  logic [iccm_pkg::LANE_W-1:0]            iccm_wr_data,
   output iccm_pkg::iccm_addr_u                   addr_inc,
   output logic [iccm_pkg::NUM_BANKS-1:0]         bank_wren,
   output logic [iccm_pkg::NUM_BANKS-1:0]         bank_rden,
   output logic [iccm_pkg::NUM_BANKS-1:0]
                [iccm_pkg::BANK_INDEX_BITS-1:0]   bank_row,
   output logic [iccm_pkg::NUM_BANKS-1:0]
                [iccm_pkg::WORD_W-1:0]            bank_wr_word
);
   import iccm_pkg::*;

   logic [ICCM_BITS-1:0] addr_step;   // Byte distance to the second word
   logic [NUM_BANKS-1:0] hit_first;   // First word lands here
   logic [NUM_BANKS-1:0] hit_second;  // Second word lands here

   // Two halfwords on DW, one otherwise
   assign addr_step = (iccm_wr_size == SIZE_DW) ? ICCM_BITS'(4) : ICCM_BITS'(2);
   assign addr_inc  = iccm_rw_addr + addr_step;      // Wraps at the top of the 1 KB

   // ************************************************************
   // Per bank enables and row select
   // ************************************************************
   for (genvar i = 0; i < NUM_BANKS; i++) begin : g_bank
      assign hit_first[i]  = (iccm_rw_addr.b.bank == BANK_BITS'(i));
      assign hit_second[i] = (addr_inc.b.bank == BANK_BITS'(i));

      assign bank_wren[i] = iccm_wren & (hit_first[i] | hit_second[i]);
      assign bank_rden[i] = iccm_rden & (hit_first[i] | hit_second[i]);

      // First word has priority, so a DW wrap from bank 3 lands on the next row
      assign bank_row[i] = hit_first[i] ? iccm_rw_addr.b.row : addr_inc.b.row;

      // Lane steering
      if (i % 2 == 0) begin : g_even
         assign bank_wr_word[i] = iccm_wr_data[WORD_W-1:0];        // Low lane
      end else begin : g_odd
         assign bank_wr_word[i] = iccm_wr_data[LANE_W-1:WORD_W];   // High lane
      end
   end

endmodule

// ==== design/iccm_mem.sv ====
`timescale 1ns/1ps
/*
   ICCM top with four banks, two redundant rows and read alignment
   Reads have a fixed one cycle latency and no handshake
   Outputs are undefined in cycles that follow no read
   One clock drives everything and array contents are not reset
*/
module iccm_mem (
   input  logic                                   clk,
   input  logic                                   rst_n,
   input  logic                                   iccm_wren,
   input  logic                                   iccm_rden,
   input  iccm_pkg::iccm_addr_u                   iccm_rw_addr,
   input  logic [2:0]                             iccm_wr_size,
   input  logic [iccm_pkg::LANE_W-1:0]            iccm_wr_data,
   input  logic                                   iccm_buf_correct_ecc,
   input  logic                                   iccm_correction_state,
   output logic [iccm_pkg::RD_W-1:0]              iccm_rd_data,
   output logic [iccm_pkg::LANE_W-1:0]            iccm_rd_data_ecc
);
   import iccm_pkg::*;

   iccm_addr_u                               addr_inc;       // Second word address
   logic [NUM_BANKS-1:0]                     bank_wren;
   logic [NUM_BANKS-1:0]                     bank_rden;
   logic [NUM_BANKS-1:0][BANK_INDEX_BITS-1:0] bank_row;
   logic [NUM_BANKS-1:0][WORD_W-1:0]         bank_wr_word;
   logic [NUM_BANKS-1:0][WORD_W-1:0]         bank_dout;      // After substitution
   logic [NUM_BANKS-1:0][1:0]                sel_red;
   logic [1:0][TAG_W-1:0]                    red_tag;
   logic [1:0]                               red_valid;
   logic [1:0][WORD_W-1:0]                   red_data;

   iccm_bank_decode i_bank_decode (
      .iccm_wren    (iccm_wren),
      .iccm_rden    (iccm_rden),
      .iccm_rw_addr (iccm_rw_addr),
      .iccm_wr_size (iccm_wr_size),
      .iccm_wr_data (iccm_wr_data),
      .addr_inc     (addr_inc),
      .bank_wren    (bank_wren),
      .bank_rden    (bank_rden),
      .bank_row     (bank_row),
      .bank_wr_word (bank_wr_word)
   );

   // ************************************************************
   // Banks
   // ************************************************************
   for (genvar i = 0; i < NUM_BANKS; i++) begin : g_bank
      iccm_bank #(
         .BANK_ID (i)
      ) i_bank (
         .clk          (clk),
         .rst_n        (rst_n),
         .bank_wren    (bank_wren[i]),
         .bank_rden    (bank_rden[i]),
         .bank_row     (bank_row[i]),
         .bank_wr_word (bank_wr_word[i]),
         .iccm_rw_addr (iccm_rw_addr),
         .addr_inc     (addr_inc),
         .red_tag      (red_tag),
         .red_valid    (red_valid),
         .red_data     (red_data),
         .sel_red      (sel_red[i]),
         .bank_dout    (bank_dout[i])
      );
   end

   iccm_redundancy i_redundancy (
      .clk                   (clk),
      .rst_n                 (rst_n),
      .iccm_wren             (iccm_wren),
      .iccm_rden             (iccm_rden),
      .iccm_rw_addr          (iccm_rw_addr),
      .iccm_wr_size          (iccm_wr_size),
      .iccm_wr_data          (iccm_wr_data),
      .iccm_buf_correct_ecc  (iccm_buf_correct_ecc),
      .iccm_correction_state (iccm_correction_state),
      .sel_red               (sel_red),
      .red_tag               (red_tag),
      .red_valid             (red_valid),
      .red_data              (red_data)
   );

   iccm_read_align i_read_align (
      .clk              (clk),
      .rst_n            (rst_n),
      .iccm_rw_addr     (iccm_rw_addr),
      .addr_inc         (addr_inc),
      .bank_dout        (bank_dout),
      .iccm_rd_data     (iccm_rd_data),
      .iccm_rd_data_ecc (iccm_rd_data_ecc)
   );

endmodule

// ==== design/iccm_pkg.sv ====
/*
   Geometry of the 1 KB ICCM with four banks of 64 words
   All sizes are fixed because the address union needs fixed field widths
   The 7 check bits of a word are stored as given and never checked
*/
package iccm_pkg;

   // ************************************************************
   // Geometry
   // ************************************************************
   localparam int ICCM_BITS       = 10;             // Byte address width
   localparam int NUM_BANKS       = 4;
   localparam int BANK_BITS       = 2;              // Bank select field
   localparam int BANK_INDEX_BITS = 6;              // Row index within a bank
   localparam int BANK_DEPTH      = 1 << BANK_INDEX_BITS;
   localparam int TAG_W           = 8;              // Address bits 9..2

   // ************************************************************
   // Word and lane widths
   // ************************************************************
   localparam int WORD_W = 39;                      // 32 data plus 7 check bits
   localparam int DATA_W = 32;
   localparam int HALF_W = 16;                      // Fetch shift step
   localparam int LANE_W = 2 * WORD_W;              // Write bus with two lanes
   localparam int RD_W   = 2 * DATA_W;

   localparam logic [2:0] SIZE_DW = 3'd3;           // Double word write size

   // Bank view used by the decoder and the aligner
   typedef struct packed {
      logic [BANK_INDEX_BITS-1:0] row;
      logic [BANK_BITS-1:0]       bank;
      logic                       hw;               // Upper halfword of the word
      logic                       byte_sel;
   } iccm_bank_view_t;

   // Tag view used by the banks and the redundant rows
   typedef struct packed {
      logic [TAG_W-1:0] tag;                        // Word address, bank in low bits
      logic [1:0]       word_off;                   // Byte offset within the word
   } iccm_tag_view_t;

   typedef union packed {
      iccm_bank_view_t b;
      iccm_tag_view_t  t;
   } iccm_addr_u;

endpackage

// ==== design/iccm_read_align.sv ====
`timescale 1ns/1ps
/*
   Read side word select and halfword alignment
   Selectors are captured every cycle so data is valid one cycle after a read
   The top 16 bits of the fetch data are always zero
*/
module iccm_read_align (
   input  logic                                   clk,
   input  logic                                   rst_n,
   input  iccm_pkg::iccm_addr_u                   iccm_rw_addr,
   input  iccm_pkg::iccm_addr_u                   addr_inc,
   input  logic [iccm_pkg::NUM_BANKS-1:0]
                [iccm_pkg::WORD_W-1:0]            bank_dout,
   output logic [iccm_pkg::RD_W-1:0]              iccm_rd_data,
   output logic [iccm_pkg::LANE_W-1:0]            iccm_rd_data_ecc
);
   import iccm_pkg::*;

   logic [BANK_BITS:0]   lo_sel_q;        // First bank and halfword bit
   logic [BANK_BITS-1:0] hi_sel_q;        // Second bank
   logic [WORD_W-1:0]    word_lo;
   logic [WORD_W-1:0]    word_hi;
   logic [RD_W-1:0]      data_pair;
   logic [RD_W-1:0]      data_shift;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         lo_sel_q <= '0;
         hi_sel_q <= '0;
      end else begin
         lo_sel_q <= {iccm_rw_addr.b.bank, iccm_rw_addr.b.hw};
         hi_sel_q <= addr_inc.b.bank;
      end
   end

   assign word_lo = bank_dout[lo_sel_q[BANK_BITS:1]];
   assign word_hi = bank_dout[hi_sel_q];

   assign iccm_rd_data_ecc = {word_hi, word_lo};                  // Raw words with check bits

   assign data_pair  = {word_hi[DATA_W-1:0], word_lo[DATA_W-1:0]};
   assign data_shift = lo_sel_q[0] ? (data_pair >> HALF_W) : data_pair;   // Odd halfword start
   assign iccm_rd_data = {{HALF_W{1'b0}}, data_shift[RD_W-HALF_W-1:0]};

endmodule

// ==== design/iccm_redundancy.sv ====
`timescale 1ns/1ps
/*
   Two redundant rows that stand in for words with hard faults
   A correction cycle loads the row picked by the LRU bit from the low lane
   Later writes to a loaded word keep its row copy current
   Row tags and data have no reset, only the valid and LRU bits do
*/
module iccm_redundancy (
   input  logic                                   clk,
   input  logic                                   rst_n,
   input  logic                                   iccm_wren,
   input  logic                                   iccm_rden,
   input  iccm_pkg::iccm_addr_u                   iccm_rw_addr,
   input  logic [2:0]                             iccm_wr_size,
   input  logic [iccm_pkg::LANE_W-1:0]            iccm_wr_data,
   input  logic                                   iccm_buf_correct_ecc,
   input  logic                                   iccm_correction_state,
   input  logic [iccm_pkg::NUM_BANKS-1:0][1:0]    sel_red,
   output logic [1:0][iccm_pkg::TAG_W-1:0]        red_tag,
   output logic [1:0]                             red_valid,
   output logic [1:0][iccm_pkg::WORD_W-1:0]       red_data
);
   import iccm_pkg::*;

   logic                  lru;            // Row to replace next
   logic                  lru_en;
   logic                  lru_in;
   logic                  is_dw;
   logic [1:0]            hit_any;        // Row hit from any bank
   logic [1:0]            load;           // Correction load per row
   logic [1:0]            wr_match;       // Write covers the stored word
   logic [1:0]            hi_lane;        // Stored word is on the high lane
   logic [1:0][WORD_W-1:0] row_din;

   assign is_dw = (iccm_wr_size == SIZE_DW);

   always_comb begin
      hit_any = 2'b00;
      for (int b = 0; b < NUM_BANKS; b++) begin
         hit_any = hit_any | sel_red[b];
      end
   end

   // ************************************************************
   // Row load and update
   // ************************************************************
   for (genvar r = 0; r < 2; r++) begin : g_row
      assign load[r] = iccm_buf_correct_ecc & (lru == 1'(r));

      // Bits 9..3 always, bit 2 only on word writes
      assign wr_match[r] = iccm_wren & red_valid[r]
                         & (iccm_rw_addr.t.tag[TAG_W-1:1] == red_tag[r][TAG_W-1:1])
                         & ((iccm_rw_addr.t.tag[0] == red_tag[r][0]) | is_dw);

      assign hi_lane[r] = ((iccm_rw_addr.t.tag[0] == red_tag[r][0]) & iccm_rw_addr.t.tag[0])
                        | (red_tag[r][0] & is_dw);

      // Correction data always from the low lane
      assign row_din[r] = (hi_lane[r] & ~load[r]) ? iccm_wr_data[LANE_W-1:WORD_W]
                                                   : iccm_wr_data[WORD_W-1:0];
   end

   always_ff @(posedge clk) begin
      for (int r = 0; r < 2; r++) begin
         if (load[r]) begin
            red_tag[r] <= iccm_rw_addr.t.tag;
         end
         if (load[r] | wr_match[r]) begin
            red_data[r] <= row_din[r];
         end
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         red_valid <= 2'b00;
      end else begin
         red_valid <= red_valid | load;   // Sticky once loaded
      end
   end

   // ************************************************************
   // LRU
   // ************************************************************
   // Toggle on correction, else steer away from a row hit mid correction
   assign lru_en = iccm_buf_correct_ecc
                 | ((|hit_any) & iccm_rden & iccm_correction_state);
   assign lru_in = iccm_buf_correct_ecc ? ~lru : hit_any[0];

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         lru <= 1'b0;
      end else if (lru_en) begin
         lru <= lru_in;
      end
   end

endmodule

// ==== verification/iccm_mem_chk.sv ====
`timescale 1ns/1ps
/*
   Assertions bound into the ICCM top
   Only active while out of reset
   Read data is checked one cycle after the read enable
*/
module iccm_mem_chk (
   input logic                                   clk,
   input logic                                   rst_n,
   input logic                                   iccm_rden,
   input logic [iccm_pkg::NUM_BANKS-1:0]         bank_wren,
   input logic [iccm_pkg::NUM_BANKS-1:0]         bank_rden,
   input logic [1:0]                             red_valid,
   input logic [iccm_pkg::RD_W-1:0]              iccm_rd_data
);
   import iccm_pkg::*;

   // Two words per access, so never more than two banks
   a_bank_enables: assert property (@(posedge clk) disable iff (!rst_n)
      ($countones(bank_wren) <= 2) && ($countones(bank_rden) <= 2))
      else $error("More than two banks enabled in one cycle");

   a_rd_top_zero: assert property (@(posedge clk) disable iff (!rst_n)
      iccm_rden |=> (iccm_rd_data[RD_W-1:RD_W-HALF_W] == '0))
      else $error("Top halfword of read data is not zero");

   // Valid bits are sticky once a row is loaded
   a_valid_sticky: assert property (@(posedge clk) disable iff (!rst_n)
      (($past(red_valid) & ~red_valid) == 2'b00))
      else $error("Redundant row valid bit fell");

endmodule

bind iccm_mem iccm_mem_chk i_iccm_mem_chk (
   .clk          (clk),
   .rst_n        (rst_n),
   .iccm_rden    (iccm_rden),
   .bank_wren    (bank_wren),
   .bank_rden    (bank_rden),
   .red_valid    (red_valid),
   .iccm_rd_data (iccm_rd_data)
);

// ==== verification/iccm_mem_tb.sv ====
`timescale 1ns/1ps
/*
   Table driven testbench for the banked ICCM
   The whole array is written first so that no read returns unwritten words
   A model of array, redundant rows and LRU gives the expected read values
   Reads are checked 1 ns after the edge that samples them
*/
module iccm_mem_tb;
   import iccm_pkg::*;

   localparam logic [1:0] OP_WR  = 2'd0;
   localparam logic [1:0] OP_RD  = 2'd1;
   localparam logic [1:0] OP_COR = 2'd2;     // Correction cycle without array write
   localparam logic [1:0] OP_RDC = 2'd3;     // Read while a correction is in progress
   localparam logic [2:0] SIZE_W = 3'd2;

   typedef struct packed {
      logic [1:0]           op;
      logic [ICCM_BITS-1:0] addr;
      logic [2:0]           size;
      logic                 exp_lru;         // LRU bit after the op
   } op_entry_t;

   logic              clk;
   logic              rst_n;
   logic              iccm_wren;
   logic              iccm_rden;
   iccm_addr_u        iccm_rw_addr;
   logic [2:0]        iccm_wr_size;
   logic [LANE_W-1:0] iccm_wr_data;
   logic              iccm_buf_correct_ecc;
   logic              iccm_correction_state;
   logic [RD_W-1:0]   iccm_rd_data;
   logic [LANE_W-1:0] iccm_rd_data_ecc;

   integer            seed = 68;
   int unsigned       edge_cnt = 0;        // Rising edges seen so far
   op_entry_t         ops[$];

   // ************************************************************
   // Reference model state
   // ************************************************************
   logic [WORD_W-1:0] mdl_mem [NUM_BANKS][BANK_DEPTH];
   logic [TAG_W-1:0]  mdl_tag [2];
   logic [WORD_W-1:0] mdl_data [2];
   logic [1:0]        mdl_valid;
   logic              mdl_lru;

   iccm_mem i_iccm_mem (.*);

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   always @(posedge clk) edge_cnt <= edge_cnt + 1;

   task automatic check_value(input string name, input logic [LANE_W-1:0] actual,
                              input logic [LANE_W-1:0] expected);
      if (actual !== expected) begin
         $display("Error at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
         $display("Simulation failed");
         $fatal(1);
      end
   endtask

   // Polls the edge counter and returns 1 ns after the last edge
   task automatic wait_cycles(input int n);
      int unsigned target;
      int          polls;
      target = edge_cnt + n;
      polls  = 0;
      while (edge_cnt < target) begin
         #1;
         polls++;
         if (polls > n * 8 + 16) begin
            $display("Clock stopped while waiting for %0d cycles", n);
            $display("Simulation failed");
            $fatal(1);
         end
      end
   endtask

   task automatic next_data(output logic [LANE_W-1:0] d);
      logic [95:0] raw;
      raw = {$random(seed), $random(seed), $random(seed)};
      d   = raw[LANE_W-1:0];
   endtask

   function automatic logic [ICCM_BITS-1:0] next_addr(input logic [ICCM_BITS-1:0] addr,
                                                       input logic [2:0] size);
      return addr + ((size == SIZE_DW) ? ICCM_BITS'(4) : ICCM_BITS'(2));   // Wraps at 1 KB
   endfunction

   // Even banks on the low lane, odd banks on the high lane
   function automatic logic [WORD_W-1:0] lane_of(input logic odd, input logic [LANE_W-1:0] d);
      return odd ? d[LANE_W-1:WORD_W] : d[WORD_W-1:0];
   endfunction

   // Array word, replaced by a valid row whose tag matches either access word
   function automatic logic [WORD_W-1:0] bank_word(input logic [1:0] b, input logic [5:0] row,
                                                    input logic [TAG_W-1:0] t1,
                                                    input logic [TAG_W-1:0] t2);
      logic [WORD_W-1:0] w;
      w = mdl_mem[b][row];
      for (int r = 0; r < 2; r++) begin
         if (mdl_valid[r] && mdl_tag[r][1:0] == b && (mdl_tag[r] == t1 || mdl_tag[r] == t2))
            w = mdl_data[r];                 // Row 1 last, so it wins
      end
      return w;
   endfunction

   task automatic expect_read(input logic [ICCM_BITS-1:0] addr, input logic [2:0] size,
                              output logic [RD_W-1:0] exp_rd,
                              output logic [LANE_W-1:0] exp_ecc);
      logic [ICCM_BITS-1:0] addr2;
      logic [5:0]           row2;
      logic [WORD_W-1:0]    w_lo;
      logic [WORD_W-1:0]    w_hi;
      logic [RD_W-1:0]      pair;
      addr2 = next_addr(addr, size);
      row2  = (addr2[3:2] == addr[3:2]) ? addr[9:4] : addr2[9:4];   // First row in a shared bank
      w_lo  = bank_word(addr[3:2], addr[9:4], addr[9:2], addr2[9:2]);
      w_hi  = bank_word(addr2[3:2], row2, addr[9:2], addr2[9:2]);
      exp_ecc = {w_hi, w_lo};
      pair    = {w_hi[DATA_W-1:0], w_lo[DATA_W-1:0]};
      if (addr[1])
         pair = pair >> HALF_W;             // Odd halfword start
      exp_rd = {{HALF_W{1'b0}}, pair[RD_W-HALF_W-1:0]};
   endtask

   task automatic model_write(input logic [ICCM_BITS-1:0] addr, input logic [2:0] size,
                              input logic [LANE_W-1:0] data);
      logic [ICCM_BITS-1:0] addr2;
      addr2 = next_addr(addr, size);
      mdl_mem[addr[3:2]][addr[9:4]] = lane_of(addr[2], data);
      if (addr2[3:2] != addr[3:2])
         mdl_mem[addr2[3:2]][addr2[9:4]] = lane_of(addr2[2], data);
      // Rows follow writes on bits 9..3, bit 2 too unless double word
      for (int r = 0; r < 2; r++) begin
         if (mdl_valid[r] && addr[9:3] == mdl_tag[r][TAG_W-1:1]
             && (addr[2] == mdl_tag[r][0] || size == SIZE_DW))
            mdl_data[r] = lane_of(mdl_tag[r][0], data);
      end
   endtask

   task automatic drive_idle();
      iccm_wren             = 1'b0;
      iccm_rden             = 1'b0;
      iccm_rw_addr          = '0;
      iccm_wr_size          = '0;
      iccm_wr_data          = '0;
      iccm_buf_correct_ecc  = 1'b0;
      iccm_correction_state = 1'b0;
   endtask

   // One op per cycle, driven 1 ns after an edge
   task automatic run_op(input logic [1:0] op, input logic [ICCM_BITS-1:0] addr,
                         input logic [2:0] size, input logic [LANE_W-1:0] data);
      logic [RD_W-1:0]      exp_rd;
      logic [LANE_W-1:0]    exp_ecc;
      logic [ICCM_BITS-1:0] addr2;
      logic [1:0]           hit;
      expect_read(addr, size, exp_rd, exp_ecc);
      addr2                 = next_addr(addr, size);
      iccm_wren             = (op == OP_WR);
      iccm_rden             = (op == OP_RD) || (op == OP_RDC);
      iccm_rw_addr          = addr;
      iccm_wr_size          = size;
      iccm_wr_data          = data;
      iccm_buf_correct_ecc  = (op == OP_COR);
      iccm_correction_state = (op == OP_COR) || (op == OP_RDC);
      case (op)
         OP_WR: model_write(addr, size, data);
         OP_COR: begin
            mdl_tag[mdl_lru]   = addr[9:2];
            mdl_data[mdl_lru]  = data[WORD_W-1:0];   // Low lane only
            mdl_valid[mdl_lru] = 1'b1;
            mdl_lru            = ~mdl_lru;
         end
         OP_RDC: begin
            for (int r = 0; r < 2; r++)
               hit[r] = mdl_valid[r] && (mdl_tag[r] == addr[9:2] || mdl_tag[r] == addr2[9:2]);
            if (|hit)
               mdl_lru = hit[0];             // Steer away from the row in use
         end
         default: ;
      endcase
      wait_cycles(1);
      if (iccm_rden) begin
         check_value("iccm_rd_data", iccm_rd_data, exp_rd);
         check_value("iccm_rd_data_ecc", iccm_rd_data_ecc, exp_ecc);
      end
   endtask

   task automatic add_op(input logic [1:0] op, input logic [ICCM_BITS-1:0] addr,
                         input logic [2:0] size, input logic exp_lru);
      ops.push_back({op, addr, size, exp_lru});
   endtask

   // ************************************************************
   // Operation table with op, address, size and LRU after
   // ************************************************************
   task automatic load_table();
      add_op(OP_WR,  10'h040, SIZE_W,  1'b0);   // Aligned word in an even bank
      add_op(OP_RD,  10'h040, SIZE_W,  1'b0);
      add_op(OP_WR,  10'h054, SIZE_W,  1'b0);   // Odd bank on the high lane
      add_op(OP_RD,  10'h054, SIZE_W,  1'b0);
      add_op(OP_WR,  10'h07C, SIZE_DW, 1'b0);   // Bank 3 wraps to bank 0 next row
      add_op(OP_RD,  10'h07C, SIZE_DW, 1'b0);
      add_op(OP_WR,  10'h3FC, SIZE_DW, 1'b0);   // Wraps at the top of memory
      add_op(OP_RD,  10'h3FC, SIZE_DW, 1'b0);
      add_op(OP_RD,  10'h046, SIZE_W,  1'b0);   // Odd halfword
      add_op(OP_RD,  10'h07E, SIZE_W,  1'b0);
      add_op(OP_COR, 10'h0A0, SIZE_W,  1'b1);   // Row 0
      add_op(OP_RD,  10'h0A0, SIZE_W,  1'b1);
      add_op(OP_WR,  10'h0A0, SIZE_W,  1'b1);   // Updates array and row 0
      add_op(OP_RD,  10'h0A0, SIZE_W,  1'b1);
      add_op(OP_COR, 10'h0B4, SIZE_W,  1'b0);   // Row 1
      add_op(OP_RD,  10'h0B4, SIZE_W,  1'b0);
      add_op(OP_WR,  10'h0B4, SIZE_W,  1'b0);
      add_op(OP_RD,  10'h0B4, SIZE_W,  1'b0);
      add_op(OP_COR, 10'h0C8, SIZE_W,  1'b1);   // Third address replaces row 0
      add_op(OP_RD,  10'h0A0, SIZE_W,  1'b1);   // Back to array data
      add_op(OP_RD,  10'h0C8, SIZE_W,  1'b1);
      add_op(OP_RDC, 10'h0B4, SIZE_W,  1'b0);   // Row 1 hit
      add_op(OP_COR, 10'h0D0, SIZE_W,  1'b1);
      add_op(OP_RD,  10'h0C8, SIZE_W,  1'b1);
      add_op(OP_RD,  10'h0B4, SIZE_W,  1'b1);
      add_op(OP_RD,  10'h0D0, SIZE_W,  1'b1);
      add_op(OP_COR, 10'h0E0, SIZE_W,  1'b0);   // Replaces row 1
      add_op(OP_RD,  10'h0B4, SIZE_W,  1'b0);
      add_op(OP_RD,  10'h0E0, SIZE_W,  1'b0);
      add_op(OP_WR,  10'h0E0, SIZE_DW, 1'b0);   // DW write matching row 1
      add_op(OP_RD,  10'h0E0, SIZE_DW, 1'b0);
      add_op(OP_RDC, 10'h0D0, SIZE_W,  1'b1);   // Row 0 hit
      add_op(OP_RDC, 10'h040, SIZE_W,  1'b1);   // No hit keeps LRU at 1
      add_op(OP_COR, 10'h0F0, SIZE_W,  1'b0);
      add_op(OP_RD,  10'h0E0, SIZE_DW, 1'b0);
      add_op(OP_RD,  10'h0D0, SIZE_W,  1'b0);
   endtask

   initial begin
      op_entry_t         e;
      logic [LANE_W-1:0] d;
      drive_idle();
      rst_n     = 1'b0;
      mdl_valid = 2'b00;
      mdl_lru   = 1'b0;
      load_table();
      wait_cycles(16);
      rst_n = 1'b1;
      for (int i = 0; i < NUM_BANKS * BANK_DEPTH; i++) begin   // Fill every word
         next_data(d);
         run_op(OP_WR, ICCM_BITS'(i * 4), SIZE_W, d);
      end
      foreach (ops[i]) begin
         e = ops[i];
         d = '0;
         if (e.op == OP_WR || e.op == OP_COR)
            next_data(d);
         run_op(e.op, e.addr, e.size, d);
         check_value("lru", i_iccm_mem.i_redundancy.lru, e.exp_lru);
      end
      drive_idle();
      wait_cycles(2);
      $display("Simulation passed");
      $finish;
   end

endmodule

// ==== verilog.f ====
design/iccm_pkg.sv
design/iccm_bank_decode.sv
design/iccm_bank.sv
design/iccm_redundancy.sv
design/iccm_read_align.sv
design/iccm_mem.sv
verification/iccm_mem_chk.sv
verification/iccm_mem_tb.sv
